// ==== src/phxDecodePkg.sv ====
package phxDecodePkg;

	// ====================
	// Encodings
	// ====================

	// Primary opcode, always in bits 5..0 of the instruction
	typedef enum logic [5:0] {
		NOP   = 6'd0,
		R2    = 6'd2,
		ADDI  = 6'd4,
		SUBFI = 6'd5,
		ANDI  = 6'd8,
		ORI   = 6'd9,
		XORI  = 6'd10,
		CMPI  = 6'd11,
		LDB   = 6'd16,
		LDBU  = 6'd17,
		LDW   = 6'd18,
		LDWU  = 6'd19,
		LDT   = 6'd20,
		STB   = 6'd24,
		STW   = 6'd25,
		STT   = 6'd26,
		BCC   = 6'd28,
		CALL  = 6'd32,
		BSR   = 6'd33,
		RET   = 6'd34,
		PFX   = 6'd63
	} opcode_e;

	// Function code of the R2 format
	typedef enum logic [5:0] {
		ADD   = 6'd0,
		SUB   = 6'd1,
		AND   = 6'd2,
		OR    = 6'd3,
		XOR   = 6'd4,
		CMP   = 6'd5,
		SLL   = 6'd8,
		SRL   = 6'd9,
		SRA   = 6'd10,
		LDBX  = 6'd16,
		LDBUX = 6'd17,
		LDWX  = 6'd18,
		LDWUX = 6'd19,
		LDTX  = 6'd20,
		STBX  = 6'd24,
		STWX  = 6'd25,
		STTX  = 6'd26
	} func_e;

	typedef enum logic [1:0] {
		BYT   = 2'd0,
		WYDE  = 2'd1,
		TETRA = 2'd2,
		VECT  = 2'd3
	} memSize_e;

	// Register numbers
	localparam logic [5:0] spRegBase = 6'd60;
	localparam logic [5:0] spAlias = 6'd31;
	// Link register n is linkRegBase + n
	localparam logic [5:0] linkRegBase = 6'd48;

	localparam int dispWidth = 16;
	localparam int pfxImmWidth = 32;

	// ====================
	// Instruction formats
	// ====================

	typedef struct packed {
		logic vec;
		logic [5:0] num;
	} regSpec_t;

	typedef union packed {
		struct packed {
			logic [6:0] pad;
			func_e func;
			regSpec_t Rb;
			regSpec_t Ra;
			regSpec_t Rt;
			opcode_e opcode;
		} r2;
		// Branches and stores put their source register Rc in the Rt slot
		struct packed {
			logic [3:0] pad;
			logic [dispWidth-1:0] imm;
			regSpec_t Ra;
			regSpec_t Rt;
			opcode_e opcode;
		} ri;
		struct packed {
			logic [31:0] target;
			logic [1:0] link;
			opcode_e opcode;
		} call;
		struct packed {
			logic [1:0] pad;
			logic [pfxImmWidth-1:0] imm;
			opcode_e opcode;
		} pfx;
	} insn_u;

	typedef struct packed {
		insn_u insn;
		insn_u prev;
	} fetchBundle_t;

	// ====================
	// Decode results
	// ====================

	typedef struct packed {
		logic br;
		logic cjb;
		logic load;
		logic loadr;
		logic loadn;
		logic loadu;
		logic store;
		logic storer;
		logic storen;
		logic mem;
		logic pfx;
		logic writes;
		memSize_e memSize;
	} opClass_t;

	typedef struct packed {
		regSpec_t Ra;
		regSpec_t Rb;
		regSpec_t Rc;
		regSpec_t Rt;
		logic hasRa;
		logic hasRb;
		logic hasRc;
		logic hasRt;
		logic rfwr;
		logic vrfwr;
		logic isVector;
		logic br;
		logic cjb;
		logic load;
		logic loadu;
		logic store;
		logic mem;
		logic pfx;
		memSize_e memSize;
		logic needSteps;
	} decodeBus_t;

endpackage

// ==== src/phxOpClass.sv ====
module phxOpClass (
	input  phxDecodePkg::insn_u insn,
	output phxDecodePkg::opClass_t cls
);
	import phxDecodePkg::*;

	always_comb begin
		cls = '0;
		cls.memSize = TETRA;
		case (insn.r2.opcode)
			R2: begin
				case (insn.r2.func)
					ADD, SUB, AND, OR, XOR, CMP, SLL, SRL, SRA:
						cls.writes = 1'b1;
					// Indexed loads
					LDBX, LDBUX: begin
						cls.loadn = 1'b1;
						cls.loadu = insn.r2.func == LDBUX;
						cls.memSize = BYT;
					end
					LDWX, LDWUX: begin
						cls.loadn = 1'b1;
						cls.loadu = insn.r2.func == LDWUX;
						cls.memSize = WYDE;
					end
					LDTX:
						cls.loadn = 1'b1;
					// Indexed stores
					STBX: begin
						cls.storen = 1'b1;
						cls.memSize = BYT;
					end
					STWX: begin
						cls.storen = 1'b1;
						cls.memSize = WYDE;
					end
					STTX:
						cls.storen = 1'b1;
					default: ;
				endcase
				cls.writes = cls.writes | cls.loadn;
			end
			ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET:
				cls.writes = 1'b1;
			LDB, LDBU: begin
				cls.loadr = 1'b1;
				cls.loadu = insn.r2.opcode == LDBU;
				cls.memSize = BYT;
			end
			LDW, LDWU: begin
				cls.loadr = 1'b1;
				cls.loadu = insn.r2.opcode == LDWU;
				cls.memSize = WYDE;
			end
			LDT:
				cls.loadr = 1'b1;
			STB: begin
				cls.storer = 1'b1;
				cls.memSize = BYT;
			end
			STW: begin
				cls.storer = 1'b1;
				cls.memSize = WYDE;
			end
			STT:
				cls.storer = 1'b1;
			BCC:
				cls.br = 1'b1;
			CALL, BSR:
				cls.cjb = 1'b1;
			PFX:
				cls.pfx = 1'b1;
			default: ;
		endcase

		// Register-displacement loads write Rt as well
		cls.writes = cls.writes | cls.loadr;
		cls.load = cls.loadr | cls.loadn;
		cls.store = cls.storer | cls.storen;
		cls.mem = cls.load | cls.store;
	end

endmodule

// ==== src/phxOperandMap.sv ====
module phxOperandMap (
	input  phxDecodePkg::insn_u insn,
	input  logic [2:0] spSel,
	input  phxDecodePkg::opClass_t cls,
	output phxDecodePkg::decodeBus_t deco
);
	import phxDecodePkg::*;

	regSpec_t rtSel;
	regSpec_t rcSel;
	logic linkUsed;
	logic vecAccess;

	// Scalar r31 maps to the stack pointer of the current mode
	function automatic regSpec_t spRemap(regSpec_t r, logic [2:0] sel);
		regSpec_t res;
		res = r;
		if (!r.vec && r.num == spAlias && sel >= 3'd1 && sel <= 3'd4)
			res.num = spRegBase + {3'b000, sel} - 6'd1;
		return res;
	endfunction

	// ====================
	// Specifier select
	// ====================

	always_comb begin
		linkUsed = cls.cjb && insn.call.link != 2'd0;

		rtSel = '0;
		if (cls.writes) begin
			rtSel = insn.ri.Rt;
		end else if (linkUsed) begin
			rtSel.vec = 1'b0;
			rtSel.num = linkRegBase + {4'b0000, insn.call.link};
		end

		// Source data of a branch or store sits in the Rt field
		rcSel = (cls.br || cls.store) ? insn.ri.Rt : '0;
	end

	// ====================
	// Decode bus
	// ====================

	always_comb begin
		deco.Ra = spRemap(insn.r2.Ra, spSel);
		deco.Rb = spRemap(insn.r2.Rb, spSel);
		deco.Rc = spRemap(rcSel, spSel);
		deco.Rt = spRemap(rtSel, spSel);

		deco.hasRa = !cls.pfx && !cls.cjb;
		deco.hasRb = insn.r2.opcode == R2;
		deco.hasRc = cls.br || cls.store;
		deco.hasRt = !cls.pfx;

		deco.vrfwr = cls.writes && rtSel.vec;
		// r0 is hardwired so a write to it is dropped
		deco.rfwr = (cls.writes && !rtSel.vec && rtSel.num != 6'd0) || linkUsed;

		deco.isVector = (deco.hasRa && deco.Ra.vec) || (deco.hasRb && deco.Rb.vec) ||
			(deco.hasRc && deco.Rc.vec) || (deco.hasRt && deco.Rt.vec);

		deco.br = cls.br;
		deco.cjb = cls.cjb;
		deco.load = cls.load;
		deco.loadu = cls.loadu;
		deco.store = cls.store;
		deco.mem = cls.mem;
		deco.pfx = cls.pfx;

		// Any vector operand widens the access to a full vector
		vecAccess = (deco.hasRa && deco.Ra.vec) ||
			((cls.loadn || cls.storen) && deco.Rb.vec) ||
			(deco.hasRt && deco.Rt.vec);
		deco.memSize = vecAccess ? VECT : cls.memSize;

		// Scalar base with displacement is a single strided access
		deco.needSteps = deco.memSize == VECT &&
			!((cls.loadr || cls.storer) && !deco.Ra.vec);
	end

endmodule

// ==== src/phxImmGen.sv ====
module phxImmGen #(
	parameter int immWidth = 128
) (
	input  phxDecodePkg::fetchBundle_t bundle,
	output logic [immWidth-1:0] imm
);
	import phxDecodePkg::*;

	logic [dispWidth-1:0] disp;
	logic [pfxImmWidth-1:0] pfxImm;
	logic pfxHit;

	always_comb begin
		disp = bundle.insn.ri.imm;
		pfxImm = bundle.prev.pfx.imm;
		pfxHit = bundle.prev.pfx.opcode == PFX;

		case (bundle.insn.r2.opcode)
			ADDI, SUBFI, ANDI, ORI, XORI, CMPI, RET,
			LDB, LDBU, LDW, LDWU, LDT, STB, STW, STT, BCC:
				imm = {{(immWidth-dispWidth){disp[dispWidth-1]}}, disp};
			// Call targets are absolute and unsigned
			CALL, BSR:
				imm = {{(immWidth-pfxImmWidth){1'b0}}, bundle.insn.call.target};
			default:
				imm = '0;
		endcase

		// A prefix word supplies everything above the displacement
		if (pfxHit)
			imm[immWidth-1:dispWidth] = {
				{(immWidth-dispWidth-pfxImmWidth){pfxImm[pfxImmWidth-1]}},
				pfxImm
			};
	end

endmodule

// ==== src/phxDecodeStage.sv ====
module phxDecodeStage #(
	parameter int immWidth = 128
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	input  phxDecodePkg::decodeBus_t decoIn,
	input  logic [immWidth-1:0] immIn,
	output logic outValid,
	input  logic outReady,
	output phxDecodePkg::decodeBus_t out,
	output logic [immWidth-1:0] imm
);

	logic accept;

	// Slot is free when empty or being drained this cycle
	assign inReady = !outValid || outReady;
	assign accept = inValid && inReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	// Payload only moves on acceptance and holds during a stall
	always_ff @(posedge clk) begin
		if (accept) begin
			out <= decoIn;
			imm <= immIn;
		end
	end

endmodule

// ==== src/phxDecoder.sv ====
module phxDecoder #(
	parameter int immWidth = 128
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	output logic inReady,
	input  phxDecodePkg::fetchBundle_t in,
	input  logic [2:0] spSel,
	output logic outValid,
	input  logic outReady,
	output phxDecodePkg::decodeBus_t out,
	output logic [immWidth-1:0] imm
);
	import phxDecodePkg::*;

	opClass_t cls;
	decodeBus_t deco;
	logic [immWidth-1:0] immComb;

	// Combinational decode of the current word
	phxOpClass u_opClass (
		.insn (in.insn),
		.cls  (cls)
	);

	phxOperandMap u_operandMap (
		.insn  (in.insn),
		.spSel (spSel),
		.cls   (cls),
		.deco  (deco)
	);

	// Immediate needs the preceding word for a prefix
	phxImmGen #(
		.immWidth (immWidth)
	) u_immGen (
		.bundle (in),
		.imm    (immComb)
	);

	phxDecodeStage #(
		.immWidth (immWidth)
	) u_decodeStage (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.decoIn   (deco),
		.immIn    (immComb),
		.outValid (outValid),
		.outReady (outReady),
		.out      (out),
		.imm      (imm)
	);

endmodule

// ==== verification/phxDecoder_asserts.sv ====
module phxDecoder_asserts #(
	parameter int immWidth = 128
) (
	input  logic clk,
	input  logic arstN,
	input  logic inValid,
	input  logic inReady,
	input  logic outValid,
	input  logic outReady,
	input  phxDecodePkg::decodeBus_t out,
	input  logic [immWidth-1:0] imm
);

	// Stalled output holds its item
	holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(out) && $stable(imm))
		else $error("decode output changed while stalled");

	oneWriteEnable: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !(out.rfwr && out.vrfwr))
		else $error("scalar and vector write enables both set");

	// Accepted word shows up one cycle later
	acceptedAppears: assert property (@(posedge clk) disable iff (!arstN)
		inValid && inReady |=> outValid)
		else $error("accepted word did not reach the output");

endmodule

bind phxDecoder phxDecoder_asserts #(
	.immWidth (immWidth)
) u_asserts (
	.clk      (clk),
	.arstN    (arstN),
	.inValid  (inValid),
	.inReady  (inReady),
	.outValid (outValid),
	.outReady (outReady),
	.out      (out),
	.imm      (imm)
);

// ==== verification/phxDecoderTb.sv ====
module phxDecoderTb;
	import phxDecodePkg::*;

	localparam int immWidth = 128;
	localparam int waitLimit = 200;
	localparam int streamLen = 40;

	logic clk;
	logic arstN;
	logic inValid;
	logic inReady;
	fetchBundle_t in;
	logic [2:0] spSel;
	logic outValid;
	logic outReady;
	decodeBus_t out;
	logic [immWidth-1:0] imm;

	integer seed;
	int errors;
	int testCount;
	int passCount;
	decodeBus_t gotBus;
	logic [immWidth-1:0] gotImm;

	phxDecoder #(
		.immWidth (immWidth)
	) u_phxDecoder (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.in       (in),
		.spSel    (spSel),
		.outValid (outValid),
		.outReady (outReady),
		.out      (out),
		.imm      (imm)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// Instruction builders
	// ====================

	function automatic regSpec_t sreg(int n);
		return {1'b0, n[5:0]};
	endfunction

	function automatic regSpec_t vreg(int n);
		return {1'b1, n[5:0]};
	endfunction

	function automatic insn_u mkR2(func_e f, regSpec_t rt, regSpec_t ra, regSpec_t rb);
		insn_u w;
		w = '0;
		w.r2.opcode = R2;
		w.r2.func = f;
		w.r2.Rt = rt;
		w.r2.Ra = ra;
		w.r2.Rb = rb;
		return w;
	endfunction

	function automatic insn_u mkRi(opcode_e op, regSpec_t rt, regSpec_t ra, logic [15:0] d);
		insn_u w;
		w = '0;
		w.ri.opcode = op;
		w.ri.Rt = rt;
		w.ri.Ra = ra;
		w.ri.imm = d;
		return w;
	endfunction

	function automatic insn_u mkCall(opcode_e op, logic [1:0] link, logic [31:0] target);
		insn_u w;
		w = '0;
		w.call.opcode = op;
		w.call.link = link;
		w.call.target = target;
		return w;
	endfunction

	function automatic insn_u mkPfx(logic [31:0] v);
		insn_u w;
		w = '0;
		w.pfx.opcode = PFX;
		w.pfx.imm = v;
		return w;
	endfunction

	// ====================
	// Reference model
	// ====================

	// Scalar r31 becomes r60..r63 for mode 1..4
	function automatic regSpec_t aliasSp(regSpec_t r, logic [2:0] sel);
		if (r == 7'd31 && sel >= 3'd1 && sel <= 3'd4)
			return 7'd59 + sel;
		return r;
	endfunction

	function automatic decodeBus_t predictBus(insn_u w, logic [2:0] sel);
		decodeBus_t e;
		logic [5:0] op;
		logic [5:0] fn;
		logic aluR, aluI, idxLd, idxSt, dLd, dSt, isBr, isCall, isPfx, isLd, isSt, wr;
		logic linkOn;
		memSize_e sz;
		regSpec_t rt;
		op = w.r2.opcode;
		fn = w.r2.func;
		aluR = op == R2 && ((fn >= ADD && fn <= CMP) || (fn >= SLL && fn <= SRA));
		idxLd = op == R2 && fn >= LDBX && fn <= LDTX;
		idxSt = op == R2 && fn >= STBX && fn <= STTX;
		aluI = op == ADDI || op == SUBFI || op == ANDI || op == ORI || op == XORI ||
			op == CMPI;
		dLd = op >= LDB && op <= LDT;
		dSt = op >= STB && op <= STT;
		isBr = op == BCC;
		isCall = op == CALL || op == BSR;
		isPfx = op == PFX;
		isLd = dLd || idxLd;
		isSt = dSt || idxSt;
		wr = aluR || aluI || isLd || op == RET;
		linkOn = isCall && w.call.link != 2'd0;

		// Size by operand letter
		sz = TETRA;
		if (op == LDB || op == LDBU || op == STB ||
			(op == R2 && (fn == LDBX || fn == LDBUX || fn == STBX)))
			sz = BYT;
		else if (op == LDW || op == LDWU || op == STW ||
			(op == R2 && (fn == LDWX || fn == LDWUX || fn == STWX)))
			sz = WYDE;

		rt = '0;
		if (wr) begin
			rt = w.ri.Rt;
		end else if (linkOn) begin
			rt.vec = 1'b0;
			rt.num = 6'd48 + w.call.link;
		end

		e = '0;
		e.Ra = aliasSp(w.r2.Ra, sel);
		e.Rb = aliasSp(w.r2.Rb, sel);
		e.Rc = (isBr || isSt) ? aliasSp(w.ri.Rt, sel) : '0;
		e.Rt = aliasSp(rt, sel);
		e.hasRa = !isPfx && !isCall;
		e.hasRb = op == R2;
		e.hasRc = isBr || isSt;
		e.hasRt = !isPfx;
		e.vrfwr = wr && rt.vec;
		e.rfwr = (wr && !rt.vec && rt.num != 6'd0) || linkOn;
		e.isVector = (e.hasRa && e.Ra.vec) || (e.hasRb && e.Rb.vec) ||
			(e.hasRc && e.Rc.vec) || (e.hasRt && e.Rt.vec);
		e.br = isBr;
		e.cjb = isCall;
		e.load = isLd;
		e.loadu = op == LDBU || op == LDWU || (op == R2 && (fn == LDBUX || fn == LDWUX));
		e.store = isSt;
		e.mem = isLd || isSt;
		e.pfx = isPfx;
		if ((e.hasRa && e.Ra.vec) || ((idxLd || idxSt) && e.Rb.vec) || (e.hasRt && e.Rt.vec))
			e.memSize = VECT;
		else
			e.memSize = sz;
		e.needSteps = e.memSize == VECT && !((dLd || dSt) && !e.Ra.vec);
		return e;
	endfunction

	function automatic logic [immWidth-1:0] predictImm(fetchBundle_t b);
		logic [immWidth-1:0] v;
		logic [5:0] op;
		op = b.insn.r2.opcode;
		v = '0;
		if (op == ADDI || op == SUBFI || op == ANDI || op == ORI || op == XORI || op == CMPI ||
			op == RET || (op >= LDB && op <= LDT) || (op >= STB && op <= STT) || op == BCC)
			v = {{(immWidth-16){b.insn.ri.imm[15]}}, b.insn.ri.imm};
		else if (op == CALL || op == BSR)
			v = {{(immWidth-32){1'b0}}, b.insn.call.target};
		if (b.prev.pfx.opcode == PFX)
			v[immWidth-1:16] = {{(immWidth-48){b.prev.pfx.imm[31]}}, b.prev.pfx.imm};
		return v;
	endfunction

	// ====================
	// Checks and handshake
	// ====================

	task automatic checkValue(string name, logic [127:0] got, logic [127:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finishTest(string name, int errStart);
		testCount++;
		if (errors == errStart) begin
			passCount++;
			$display("%s: passed", name);
		end else begin
			$display("%s: %0d mismatches", name, errors - errStart);
		end
	endtask

	task automatic timeoutAbort(string what);
		$display("Timed out after %0d cycles waiting for %s", waitLimit, what);
		$display("TEST FAILED");
		$finish;
	endtask

	// Returns before the edge that accepts the word
	task automatic sendWord(insn_u w, insn_u prev, logic [2:0] sel);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		in.insn = w;
		in.prev = prev;
		spSel = sel;
		inValid = 1'b1;
		#1;
		while (!inReady && waited < waitLimit) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!inReady)
			timeoutAbort("inReady");
	endtask

	task automatic collectWord();
		int waited;
		waited = 0;
		while (!outValid && waited < waitLimit) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!outValid)
			timeoutAbort("outValid");
		gotBus = out;
		gotImm = imm;
	endtask

	task automatic decodeOne(insn_u w, insn_u prev, logic [2:0] sel);
		sendWord(w, prev, sel);
		@(posedge clk);
		#1;
		inValid = 1'b0;
		collectWord();
		checkValue("out", gotBus, predictBus(w, sel));
		checkValue("imm", gotImm, predictImm({w, prev}));
	endtask

	// Random word from the ALU, memory and control groups
	task automatic randomInsn(output insn_u w);
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		w = r[39:0];
		case (r[63:61])
			3'd0: begin
				w.r2.opcode = R2;
				w.r2.func = r[60] ? SUB : ADD;
			end
			3'd1: w.ri.opcode = r[60] ? CMPI : ADDI;
			3'd2: begin
				case (r[59:58])
					2'd0: w.ri.opcode = LDB;
					2'd1: w.ri.opcode = LDWU;
					2'd2: w.ri.opcode = LDT;
					default: w.ri.opcode = LDW;
				endcase
			end
			3'd3: begin
				case (r[59:58])
					2'd0: w.ri.opcode = STB;
					2'd1: w.ri.opcode = STT;
					default: w.ri.opcode = STW;
				endcase
			end
			3'd4: begin
				w.r2.opcode = R2;
				case (r[60:58])
					3'd0: w.r2.func = LDBX;
					3'd1: w.r2.func = LDBUX;
					3'd2: w.r2.func = LDWX;
					3'd3: w.r2.func = LDWUX;
					3'd4: w.r2.func = LDTX;
					3'd5: w.r2.func = STBX;
					3'd6: w.r2.func = STWX;
					default: w.r2.func = STTX;
				endcase
			end
			3'd5: w.ri.opcode = BCC;
			3'd6: w.call.opcode = r[60] ? BSR : CALL;
			default: w.ri.opcode = RET;
		endcase
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic testAlu();
		int e0;
		e0 = errors;
		decodeOne(mkR2(ADD, sreg(5), sreg(6), sreg(7)), '0, 3'd0);
		checkValue("out.rfwr", gotBus.rfwr, 1);
		checkValue("out.vrfwr", gotBus.vrfwr, 0);
		checkValue("out.Ra", gotBus.Ra, sreg(6));
		checkValue("out.Rb", gotBus.Rb, sreg(7));
		checkValue("out.hasRb", gotBus.hasRb, 1);
		decodeOne(mkR2(SUB, vreg(3), sreg(1), vreg(2)), '0, 3'd0);
		checkValue("out.rfwr", gotBus.rfwr, 0);
		checkValue("out.vrfwr", gotBus.vrfwr, 1);
		checkValue("out.Rt", gotBus.Rt, vreg(3));
		checkValue("out.Rb", gotBus.Rb, vreg(2));
		decodeOne(mkRi(ADDI, sreg(4), sreg(2), 16'hFF80), '0, 3'd0);
		checkValue("imm", gotImm, {{112{1'b1}}, 16'hFF80});
		checkValue("out.hasRb", gotBus.hasRb, 0);
		decodeOne(mkRi(CMPI, sreg(4), sreg(2), 16'h1234), '0, 3'd0);
		checkValue("imm", gotImm, 128'h1234);
		// Write to r0 is dropped
		decodeOne(mkR2(ADD, sreg(0), sreg(1), sreg(2)), '0, 3'd0);
		checkValue("out.rfwr", gotBus.rfwr, 0);
		checkValue("out.vrfwr", gotBus.vrfwr, 0);
		finishTest("alu", e0);
	endtask

	task automatic testMem();
		int e0;
		e0 = errors;
		decodeOne(mkRi(LDB, sreg(3), sreg(4), 16'h0010), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, BYT);
		checkValue("out.loadu", gotBus.loadu, 0);
		checkValue("out.load", gotBus.load, 1);
		decodeOne(mkRi(LDWU, sreg(3), sreg(4), 16'h0010), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, WYDE);
		checkValue("out.loadu", gotBus.loadu, 1);
		decodeOne(mkRi(LDT, sreg(3), sreg(4), 16'h0010), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, TETRA);
		checkValue("out.loadu", gotBus.loadu, 0);
		decodeOne(mkRi(STW, sreg(9), sreg(2), 16'h0008), '0, 3'd0);
		checkValue("out.Rc", gotBus.Rc, sreg(9));
		checkValue("out.rfwr", gotBus.rfwr, 0);
		checkValue("out.hasRc", gotBus.hasRc, 1);
		checkValue("out.store", gotBus.store, 1);
		decodeOne(mkR2(LDTX, vreg(5), sreg(1), sreg(2)), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, VECT);
		checkValue("out.needSteps", gotBus.needSteps, 1);
		// Scalar base plus displacement stays one access
		decodeOne(mkRi(LDT, vreg(5), sreg(1), 16'h0020), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, VECT);
		checkValue("out.needSteps", gotBus.needSteps, 0);
		decodeOne(mkR2(STBX, sreg(3), sreg(4), vreg(5)), '0, 3'd0);
		checkValue("out.memSize", gotBus.memSize, VECT);
		finishTest("loadStore", e0);
	endtask

	task automatic testFlow();
		int e0;
		e0 = errors;
		decodeOne(mkRi(BCC, sreg(7), sreg(8), 16'h8004), '0, 3'd0);
		checkValue("out.br", gotBus.br, 1);
		checkValue("out.hasRc", gotBus.hasRc, 1);
		checkValue("out.Rc", gotBus.Rc, sreg(7));
		checkValue("imm", gotImm, {{112{1'b1}}, 16'h8004});
		decodeOne(mkCall(CALL, 2'd2, 32'h89AB_CDEF), '0, 3'd0);
		checkValue("out.Rt", gotBus.Rt, sreg(50));
		checkValue("out.rfwr", gotBus.rfwr, 1);
		checkValue("out.hasRa", gotBus.hasRa, 0);
		checkValue("imm", gotImm, 128'h89AB_CDEF);
		decodeOne(mkCall(BSR, 2'd0, 32'h0000_4000), '0, 3'd0);
		checkValue("out.rfwr", gotBus.rfwr, 0);
		checkValue("out.Rt", gotBus.Rt, 0);
		finishTest("controlFlow", e0);
	endtask

	task automatic testSpRemap();
		int e0;
		int s;
		int expNum;
		e0 = errors;
		for (s = 0; s < 6; s++) begin
			decodeOne(mkR2(ADD, sreg(31), sreg(31), sreg(31)), '0, s[2:0]);
			expNum = (s >= 1 && s <= 4) ? 59 + s : 31;
			checkValue("out.Ra", gotBus.Ra, sreg(expNum));
			checkValue("out.Rb", gotBus.Rb, sreg(expNum));
			checkValue("out.Rt", gotBus.Rt, sreg(expNum));
		end
		decodeOne(mkR2(ADD, vreg(31), vreg(31), vreg(31)), '0, 3'd2);
		checkValue("out.Ra", gotBus.Ra, vreg(31));
		checkValue("out.Rt", gotBus.Rt, vreg(31));
		finishTest("spRemap", e0);
	endtask

	task automatic testPrefix();
		int e0;
		e0 = errors;
		decodeOne(mkRi(ADDI, sreg(3), sreg(4), 16'h1234), mkPfx(32'h8000_0001), 3'd0);
		checkValue("imm", gotImm, {{80{1'b1}}, 32'h8000_0001, 16'h1234});
		decodeOne(mkPfx(32'h0000_0055), '0, 3'd0);
		checkValue("out.pfx", gotBus.pfx, 1);
		checkValue("out.hasRt", gotBus.hasRt, 0);
		checkValue("out.rfwr", gotBus.rfwr, 0);
		checkValue("out.vrfwr", gotBus.vrfwr, 0);
		finishTest("prefix", e0);
	endtask

	task automatic testBackPressure();
		insn_u words[streamLen];
		logic [2:0] sels[streamLen];
		int e0;
		int i;
		int count;
		int idle;
		e0 = errors;
		for (i = 0; i < streamLen; i++) begin
			randomInsn(words[i]);
			sels[i] = $random(seed);
		end
		fork
			begin
				for (int k = 0; k < streamLen; k++)
					sendWord(words[k], '0, sels[k]);
				@(posedge clk);
				#1;
				inValid = 1'b0;
			end
			begin
				count = 0;
				idle = 0;
				while (count < streamLen) begin
					@(posedge clk);
					#1;
					outReady = $random(seed);
					#1;
					if (outValid && outReady) begin
						checkValue("out", out, predictBus(words[count], sels[count]));
						checkValue("imm", imm, predictImm({words[count], 40'd0}));
						count++;
						idle = 0;
					end else begin
						idle++;
						if (idle > waitLimit)
							timeoutAbort("a decoded instruction");
					end
				end
			end
		join
		outReady = 1'b1;
		// Nothing may follow the last instruction
		@(posedge clk);
		#2;
		checkValue("outValid", outValid, 0);
		finishTest("backPressure", e0);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed = 83665;
		errors = 0;
		testCount = 0;
		passCount = 0;
		arstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b0;
		in = '0;
		spSel = 3'd0;
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		outReady = 1'b1;
		#1;
		checkValue("outValid", outValid, 0);
		checkValue("inReady", inReady, 1);

		testAlu();
		testMem();
		testFlow();
		testSpRemap();
		testPrefix();
		testBackPressure();

		$display("%0d of %0d tests passed, %0d mismatches", passCount, testCount, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
src/phxDecodePkg.sv
src/phxOpClass.sv
src/phxOperandMap.sv
src/phxImmGen.sv
src/phxDecodeStage.sv
src/phxDecoder.sv
verification/phxDecoder_asserts.sv
verification/phxDecoderTb.sv

// ==== Bender.yml ====
package:
  name: phx_decoder

sources:
  - files:
      - src/phxDecodePkg.sv
      - src/phxOpClass.sv
      - src/phxOperandMap.sv
      - src/phxImmGen.sv
      - src/phxDecodeStage.sv
      - src/phxDecoder.sv
  - target: test
    files:
      - verification/phxDecoder_asserts.sv
      - verification/phxDecoderTb.sv
